//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
TOP       ?= mmu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
+incdir+hw
hw/mmu_pkg.sv
hw/mmu_csr.sv
hw/mmu_walker.sv
hw/mmu_top.sv
sim/mmu_chk.sv
sim/mmu_tb.sv

//--- hw/mmu_cfg.svh
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Bus and address widths.
`define MMU_PA_W        56
`define MMU_VA_W        39
`define MMU_DATA_W      64
`define MMU_PPN_W       44
`define MMU_SRC_W       4

// Sv39 PTE layout.
`define PTE_V           0
`define PTE_R           1
`define PTE_W           2
`define PTE_X           3
`define PTE_PPN_LSB     10

// satp mode field.
`define SATP_MODE_W     4
`define SATP_MODE_SV39  4'd8

`endif

//--- hw/mmu_csr.sv
`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mmu_csr import mmu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        csr_we,
    input  csr_sel_e                    csr_sel,
    input  logic [`MMU_DATA_W-1:0]      csr_wdata,
    output logic [`MMU_DATA_W-1:0]      csr_rdata,
    input  logic                        fault,
    input  logic [`MMU_VA_W-1:0]        fault_vaddr,
    output logic [`SATP_MODE_W-1:0]     satp_mode,
    output logic [`MMU_PPN_W-1:0]       root_ppn
);

    logic [`MMU_DATA_W-1:0] satp_q;
    logic [`MMU_DATA_W-1:0] stval_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            satp_q <= '0;
        end else if (csr_we && csr_sel == csr_satp) begin
            satp_q <= csr_wdata;
        end
    end

    // Hardware capture wins over a software write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stval_q <= '0;
        end else if (fault) begin
            stval_q <= {{(`MMU_DATA_W-`MMU_VA_W){1'b0}}, fault_vaddr};  // Zero extended VA.
        end else if (csr_we && csr_sel == csr_stval) begin
            stval_q <= csr_wdata;
        end
    end

    assign csr_rdata = (csr_sel == csr_satp) ? satp_q : stval_q;

    assign satp_mode = satp_q[`MMU_DATA_W-1 -: `SATP_MODE_W];  // Mode in the top nibble.
    assign root_ppn  = satp_q[`MMU_PPN_W-1:0];

endmodule

//--- hw/mmu_pkg.sv
package mmu_pkg;

    typedef enum logic [3:0] {
        st_idle,
        st_l2_req,     // Root table read.
        st_l2_data,
        st_l1_req,
        st_l1_data,
        st_l0_req,
        st_l0_data,
        st_access,     // Original request at the physical address.
        st_reply,
        st_fault
    } walk_state_e;

    // TileLink opcodes, A and D channels share the encoding space.
    typedef enum logic [2:0] {
        op_put_full       = 3'd0,
        op_access_ack_data = 3'd1,
        op_get            = 3'd4
    } bus_op_e;

    localparam bus_op_e op_access_ack = op_put_full;  // D channel AccessAck is also 0.

    typedef enum logic {
        csr_satp,
        csr_stval
    } csr_sel_e;

endpackage

//--- hw/mmu_top.sv
`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mmu_top import mmu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        virt_a_valid,
    output logic                        virt_a_ready,
    input  bus_op_e                     virt_a_opcode,
    input  logic [`MMU_VA_W-1:0]        virt_a_address,
    input  logic [`MMU_DATA_W/8-1:0]    virt_a_mask,
    input  logic [`MMU_DATA_W-1:0]      virt_a_data,
    input  logic [`MMU_SRC_W-1:0]       virt_a_source,
    output logic                        virt_d_valid,
    input  logic                        virt_d_ready,
    output bus_op_e                     virt_d_opcode,
    output logic [`MMU_DATA_W-1:0]      virt_d_data,
    output logic                        virt_d_denied,
    output logic [`MMU_SRC_W-1:0]       virt_d_source,

    output logic                        phy_a_valid,
    input  logic                        phy_a_ready,
    output bus_op_e                     phy_a_opcode,
    output logic [`MMU_PA_W-1:0]        phy_a_address,
    output logic [`MMU_DATA_W/8-1:0]    phy_a_mask,
    output logic [`MMU_DATA_W-1:0]      phy_a_data,
    output logic [`MMU_SRC_W-1:0]       phy_a_source,
    input  logic                        phy_d_valid,
    output logic                        phy_d_ready,
    input  bus_op_e                     phy_d_opcode,
    input  logic [`MMU_DATA_W-1:0]      phy_d_data,
    input  logic                        phy_d_denied,
    input  logic [`MMU_SRC_W-1:0]       phy_d_source,

    input  logic                        csr_we,
    input  csr_sel_e                    csr_sel,
    input  logic [`MMU_DATA_W-1:0]      csr_wdata,
    output logic [`MMU_DATA_W-1:0]      csr_rdata,

    output logic                        page_fault
);

    logic [`SATP_MODE_W-1:0]    satp_mode;
    logic [`MMU_PPN_W-1:0]      root_ppn;
    logic [`MMU_VA_W-1:0]       fault_vaddr;

    mmu_csr u_csr (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_we      (csr_we),
        .csr_sel     (csr_sel),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .fault       (page_fault),  // Same pulse the processor sees.
        .fault_vaddr (fault_vaddr),
        .satp_mode   (satp_mode),
        .root_ppn    (root_ppn)
    );

    mmu_walker u_walker (
        .clk            (clk),
        .rst_n          (rst_n),
        .satp_mode      (satp_mode),
        .root_ppn       (root_ppn),
        .virt_a_valid   (virt_a_valid),
        .virt_a_ready   (virt_a_ready),
        .virt_a_opcode  (virt_a_opcode),
        .virt_a_address (virt_a_address),
        .virt_a_mask    (virt_a_mask),
        .virt_a_data    (virt_a_data),
        .virt_a_source  (virt_a_source),
        .virt_d_valid   (virt_d_valid),
        .virt_d_ready   (virt_d_ready),
        .virt_d_opcode  (virt_d_opcode),
        .virt_d_data    (virt_d_data),
        .virt_d_denied  (virt_d_denied),
        .virt_d_source  (virt_d_source),
        .phy_a_valid    (phy_a_valid),
        .phy_a_ready    (phy_a_ready),
        .phy_a_opcode   (phy_a_opcode),
        .phy_a_address  (phy_a_address),
        .phy_a_mask     (phy_a_mask),
        .phy_a_data     (phy_a_data),
        .phy_a_source   (phy_a_source),
        .phy_d_valid    (phy_d_valid),
        .phy_d_ready    (phy_d_ready),
        .phy_d_opcode   (phy_d_opcode),
        .phy_d_data     (phy_d_data),
        .phy_d_denied   (phy_d_denied),
        .phy_d_source   (phy_d_source),
        .page_fault     (page_fault),
        .fault_vaddr    (fault_vaddr)
    );

endmodule

//--- hw/mmu_walker.sv
`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mmu_walker import mmu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`SATP_MODE_W-1:0]     satp_mode,
    input  logic [`MMU_PPN_W-1:0]       root_ppn,

    input  logic                        virt_a_valid,
    output logic                        virt_a_ready,
    input  bus_op_e                     virt_a_opcode,
    input  logic [`MMU_VA_W-1:0]        virt_a_address,
    input  logic [`MMU_DATA_W/8-1:0]    virt_a_mask,
    input  logic [`MMU_DATA_W-1:0]      virt_a_data,
    input  logic [`MMU_SRC_W-1:0]       virt_a_source,
    output logic                        virt_d_valid,
    input  logic                        virt_d_ready,
    output bus_op_e                     virt_d_opcode,
    output logic [`MMU_DATA_W-1:0]      virt_d_data,
    output logic                        virt_d_denied,
    output logic [`MMU_SRC_W-1:0]       virt_d_source,

    output logic                        phy_a_valid,
    input  logic                        phy_a_ready,
    output bus_op_e                     phy_a_opcode,
    output logic [`MMU_PA_W-1:0]        phy_a_address,
    output logic [`MMU_DATA_W/8-1:0]    phy_a_mask,
    output logic [`MMU_DATA_W-1:0]      phy_a_data,
    output logic [`MMU_SRC_W-1:0]       phy_a_source,
    input  logic                        phy_d_valid,
    output logic                        phy_d_ready,
    input  bus_op_e                     phy_d_opcode,
    input  logic [`MMU_DATA_W-1:0]      phy_d_data,
    input  logic                        phy_d_denied,
    input  logic [`MMU_SRC_W-1:0]       phy_d_source,

    output logic                        page_fault,
    output logic [`MMU_VA_W-1:0]        fault_vaddr
);

    walk_state_e                state, next_state;
    logic                       paging;
    logic                       bypass;
    logic                       walk_wait;
    logic                       d_fire;
    logic                       issue;

    logic                       a_valid_q;
    bus_op_e                    a_opcode_q;
    logic [`MMU_PA_W-1:0]       a_address_q;
    logic [`MMU_DATA_W/8-1:0]   a_mask_q;
    logic [`MMU_DATA_W-1:0]     a_data_q;
    logic [`MMU_SRC_W-1:0]      a_source_q;

    bus_op_e                    sav_opcode;
    logic [`MMU_VA_W-1:0]       sav_vaddr;
    logic [`MMU_DATA_W/8-1:0]   sav_mask;
    logic [`MMU_DATA_W-1:0]     sav_data;
    logic [`MMU_SRC_W-1:0]      sav_source;

    logic [`MMU_DATA_W-1:0]     pte_q;
    bus_op_e                    rsp_opcode_q;
    logic [`MMU_DATA_W-1:0]     rsp_data_q;
    logic                       rsp_denied_q;
    logic [`MMU_SRC_W-1:0]      rsp_source_q;

    logic                       pte_branch;
    logic                       pte_leaf;
    logic [`MMU_PPN_W-1:0]      pte_ppn;
    logic [`MMU_PA_W-1:0]       root_pte_addr;
    logic [`MMU_PA_W-1:0]       next_pte_addr;
    logic [`MMU_PA_W-1:0]       leaf_addr;
    logic [`MMU_PA_W-1:0]       issue_addr;

    assign paging    = (satp_mode == `SATP_MODE_SV39);
    assign bypass    = (state == st_idle) && !paging;  // Bare mode only between walks.
    assign walk_wait = state inside {st_l2_req, st_l1_req, st_l0_req, st_access};
    assign d_fire    = phy_d_valid && walk_wait;

    // PTE classification.
    assign pte_ppn    = pte_q[`PTE_PPN_LSB +: `MMU_PPN_W];
    assign pte_branch = pte_q[`PTE_V] && !pte_q[`PTE_R] && !pte_q[`PTE_W] && !pte_q[`PTE_X];
    assign pte_leaf   = pte_q[`PTE_V] && (pte_q[`PTE_R] || pte_q[`PTE_X])
                        && !(pte_q[`PTE_W] && !pte_q[`PTE_R]);  // W without R is reserved.

    assign root_pte_addr = {root_ppn, virt_a_address[`MMU_VA_W-1:30], 3'b000};
    assign next_pte_addr = (state == st_l2_data) ? {pte_ppn, sav_vaddr[29:21], 3'b000}
                                                 : {pte_ppn, sav_vaddr[20:12], 3'b000};

    always_comb begin
        case (state)
            st_l2_data: leaf_addr = {pte_ppn[`MMU_PPN_W-1:18], sav_vaddr[29:0]};  // 1 GiB.
            st_l1_data: leaf_addr = {pte_ppn[`MMU_PPN_W-1:9], sav_vaddr[20:0]};   // 2 MiB.
            default:    leaf_addr = {pte_ppn, sav_vaddr[11:0]};
        endcase
    end

    always_comb begin
        case (next_state)
            st_l2_req: issue_addr = root_pte_addr;
            st_access: issue_addr = leaf_addr;
            default:   issue_addr = next_pte_addr;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:    if (paging && virt_a_valid) next_state = st_l2_req;
            st_l2_req:  if (d_fire) next_state = st_l2_data;
            st_l1_req:  if (d_fire) next_state = st_l1_data;
            st_l0_req:  if (d_fire) next_state = st_l0_data;
            st_l2_data: begin
                if (pte_leaf) next_state = st_access;
                else if (pte_branch) next_state = st_l1_req;
                else next_state = st_fault;
            end
            st_l1_data: begin
                if (pte_leaf) next_state = st_access;
                else if (pte_branch) next_state = st_l0_req;
                else next_state = st_fault;
            end
            st_l0_data: next_state = pte_leaf ? st_access : st_fault;  // No level below.
            st_access:  if (d_fire) next_state = st_reply;
            st_reply:   if (virt_d_ready) next_state = st_idle;
            st_fault:   next_state = st_reply;
            default:    next_state = st_idle;
        endcase
    end

    assign issue = (next_state != state)
                   && (next_state inside {st_l2_req, st_l1_req, st_l0_req, st_access});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            a_valid_q <= 1'b0;
        end else begin
            state <= next_state;
            if (issue) begin
                a_valid_q <= 1'b1;
            end else if (a_valid_q && phy_a_ready) begin
                a_valid_q <= 1'b0;  // Beat accepted.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && paging && virt_a_valid) begin
            sav_opcode <= virt_a_opcode;
            sav_vaddr  <= virt_a_address;
            sav_mask   <= virt_a_mask;
            sav_data   <= virt_a_data;
            sav_source <= virt_a_source;
        end
        if (issue) begin
            a_address_q <= issue_addr;
            if (next_state == st_access) begin
                a_opcode_q <= sav_opcode;  // Replay the saved request.
                a_mask_q   <= sav_mask;
                a_data_q   <= sav_data;
                a_source_q <= sav_source;
            end else begin
                a_opcode_q <= op_get;  // 8-byte PTE read.
                a_mask_q   <= '1;
                a_data_q   <= '0;
                a_source_q <= '0;
            end
        end
        if (d_fire && state != st_access) begin
            pte_q <= phy_d_data;
        end
        if (d_fire && state == st_access) begin
            rsp_opcode_q <= phy_d_opcode;
            rsp_data_q   <= phy_d_data;
            rsp_denied_q <= phy_d_denied;
            rsp_source_q <= phy_d_source;
        end else if (state == st_fault) begin
            rsp_opcode_q <= (sav_opcode == op_get) ? op_access_ack_data : op_access_ack;
            rsp_data_q   <= '0;
            rsp_denied_q <= 1'b1;
            rsp_source_q <= sav_source;
        end
    end

    // Bare mode is a straight wire path in both directions.
    assign phy_a_valid   = bypass ? virt_a_valid : a_valid_q;
    assign phy_a_opcode  = bypass ? virt_a_opcode : a_opcode_q;
    assign phy_a_address = bypass ? {{(`MMU_PA_W-`MMU_VA_W){1'b0}}, virt_a_address}
                                  : a_address_q;
    assign phy_a_mask    = bypass ? virt_a_mask : a_mask_q;
    assign phy_a_data    = bypass ? virt_a_data : a_data_q;
    assign phy_a_source  = bypass ? virt_a_source : a_source_q;
    assign phy_d_ready   = bypass ? virt_d_ready : walk_wait;

    assign virt_a_ready  = bypass ? phy_a_ready : (state == st_idle && virt_a_valid);
    assign virt_d_valid  = bypass ? phy_d_valid : (state == st_reply);
    assign virt_d_opcode = bypass ? phy_d_opcode : rsp_opcode_q;
    assign virt_d_data   = bypass ? phy_d_data : rsp_data_q;
    assign virt_d_denied = bypass ? phy_d_denied : rsp_denied_q;
    assign virt_d_source = bypass ? phy_d_source : rsp_source_q;

    assign page_fault  = (state == st_fault);  // One cycle, fault always goes on to reply.
    assign fault_vaddr = sav_vaddr;

endmodule

//--- sim/mmu_chk.sv
`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mmu_chk (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    phy_a_valid,
    input  logic                    phy_a_ready,
    input  logic [`MMU_PA_W-1:0]    phy_a_address,
    input  logic                    virt_d_valid,
    input  logic                    virt_d_ready,
    input  logic                    page_fault
);

    // A stalled beat keeps valid and address until the slave takes it.
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        phy_a_valid && !phy_a_ready |=> phy_a_valid && $stable(phy_a_address))
        else $error("phy_a beat changed while phy_a_ready was low");

    d_hold: assert property (@(posedge clk) disable iff (!rst_n)
        virt_d_valid && !virt_d_ready |=> virt_d_valid)  // Reply held.
        else $error("virt_d_valid dropped before virt_d_ready");

    fault_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        page_fault |=> !page_fault)
        else $error("page_fault stayed high for two cycles");

    // The denied reply comes right after the pulse.
    fault_reply: assert property (@(posedge clk) disable iff (!rst_n)
        page_fault |=> virt_d_valid)
        else $error("no reply after page_fault");

endmodule

//--- sim/mmu_tb.sv
`timescale 1ns/1ns
`include "mmu_cfg.svh"

module mmu_tb import mmu_pkg::*; ();

    localparam logic [63:0]            satp_sv39 = {`SATP_MODE_SV39, 16'h0, 44'h100};
    localparam logic [`MMU_SRC_W-1:0]  req_src = 4'ha;  // Walker reads use source 0.
    localparam int                     timeout_cycles = 200;

    typedef struct packed {
        logic [63:0]            satp;
        bus_op_e                op;
        logic [`MMU_VA_W-1:0]   va;
        logic [63:0]            wdata;
        logic [`MMU_PA_W-1:0]   pa;
        logic [63:0]            rdata;
        logic                   fault;
    } vec_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       virt_a_valid;
    logic                       virt_a_ready;
    bus_op_e                    virt_a_opcode;
    logic [`MMU_VA_W-1:0]       virt_a_address;
    logic [`MMU_DATA_W/8-1:0]   virt_a_mask;
    logic [`MMU_DATA_W-1:0]     virt_a_data;
    logic [`MMU_SRC_W-1:0]      virt_a_source;
    logic                       virt_d_valid;
    logic                       virt_d_ready;
    bus_op_e                    virt_d_opcode;
    logic [`MMU_DATA_W-1:0]     virt_d_data;
    logic                       virt_d_denied;
    logic [`MMU_SRC_W-1:0]      virt_d_source;
    logic                       phy_a_valid;
    logic                       phy_a_ready = 1'b0;
    bus_op_e                    phy_a_opcode;
    logic [`MMU_PA_W-1:0]       phy_a_address;
    logic [`MMU_DATA_W/8-1:0]   phy_a_mask;
    logic [`MMU_DATA_W-1:0]     phy_a_data;
    logic [`MMU_SRC_W-1:0]      phy_a_source;
    logic                       phy_d_valid = 1'b0;
    logic                       phy_d_ready;
    bus_op_e                    phy_d_opcode = op_access_ack;
    logic [`MMU_DATA_W-1:0]     phy_d_data = '0;
    logic                       phy_d_denied = 1'b0;
    logic [`MMU_SRC_W-1:0]      phy_d_source = '0;
    logic                       csr_we;
    csr_sel_e                   csr_sel;
    logic [`MMU_DATA_W-1:0]     csr_wdata;
    logic [`MMU_DATA_W-1:0]     csr_rdata;
    logic                       page_fault;

    logic [63:0]                mem [logic [`MMU_PA_W-4:0]];  // Keyed by word address.
    logic [`MMU_PA_W-1:0]       last_pa = '0;
    logic                       reply_ready_rnd = 1'b0;
    int                         acc_cnt = 0;
    int                         fault_cnt = 0;
    integer                     seed = 53;
    vec_t                       vecs [9];

    mmu_top u_mmu_top (.*);

    bind mmu_walker mmu_chk u_chk (.*);

    always #20 clk = ~clk;

    function automatic logic [63:0] fill_word(input logic [`MMU_PA_W-1:0] pa);
        return {8'h5a, pa} ^ 64'h0000_00ff_0000_00ff;
    endfunction

    task automatic store_word(input logic [`MMU_PA_W-1:0] pa, input logic [63:0] word);
        mem[pa[`MMU_PA_W-1:3]] = word;
    endtask

    // Root table at PPN 0x100, level-1 table at 0x101, level-0 table at 0x102.
    task automatic load_tables();
        store_word(56'h10_0008, 64'h0000_0000_3000_000f);  // VPN2 1 maps a 1 GiB leaf at 0xc0000.
        store_word(56'h10_0010, 64'h0000_0000_0004_0401);  // VPN2 2 branches to 0x101.
        store_word(56'h10_0018, 64'h0000_0000_0008_000e);  // VPN2 3 has V clear.
        store_word(56'h10_0020, 64'h0000_0000_0008_0005);  // VPN2 4 has W without R.
        store_word(56'h10_1018, 64'h0000_0000_2008_0003);  // VPN1 3 maps a 2 MiB leaf at 0x80200.
        store_word(56'h10_1020, 64'h0000_0000_0004_0801);  // VPN1 4 branches to 0x102.
        store_word(56'h10_2028, 64'h0000_0000_000d_1407);  // VPN0 5 maps a 4 KiB leaf at 0x345.
        store_word(56'h10_2030, 64'h0000_0000_0004_0c01);  // VPN0 6 is a branch at the last level.
        store_word(56'h12_3450, 64'h0bad_f00d_1234_5678);
        store_word(56'hc1_2345_68, 64'h1111_2222_3333_4444);
        store_word(56'h80_2123_40, 64'h5555_6666_7777_8888);
        store_word(56'h34_5678, 64'h9999_aaaa_bbbb_cccc);
    endtask

    // Memory model replies one cycle after the A beat and takes no beat while a reply waits.
    always @(posedge clk) begin
        logic [31:0]            rnd;
        logic [`MMU_PA_W-4:0]   key;
        logic [63:0]            word;
        logic                   busy;
        int                     b;
        if (!rst_n) begin
            load_tables();
            phy_a_ready <= 1'b0;
            phy_d_valid <= 1'b0;
        end else begin
            rnd  = $random(seed);
            busy = phy_d_valid && !phy_d_ready;
            if (phy_a_valid && phy_a_ready) begin
                key  = phy_a_address[`MMU_PA_W-1:3];
                word = mem.exists(key) ? mem[key] : fill_word(phy_a_address);
                if (phy_a_opcode == op_put_full) begin
                    for (b = 0; b < 8; b = b + 1) begin
                        if (phy_a_mask[b]) begin
                            word[8*b +: 8] = phy_a_data[8*b +: 8];
                        end
                    end
                    mem[key] = word;
                    phy_d_opcode <= op_access_ack;
                    phy_d_data   <= '0;
                end else begin
                    phy_d_opcode <= op_access_ack_data;
                    phy_d_data   <= word;
                end
                phy_d_valid  <= 1'b1;
                phy_d_source <= phy_a_source;
                if (phy_a_source == req_src) begin  // Final access rather than a PTE read.
                    last_pa <= phy_a_address;
                    acc_cnt <= acc_cnt + 1;
                end
                busy = 1'b1;
            end else if (phy_d_valid && phy_d_ready) begin
                phy_d_valid <= 1'b0;
            end
            phy_a_ready     <= rnd[0] && !busy;
            reply_ready_rnd <= rnd[1];
        end
    end

    always @(posedge clk) begin
        if (rst_n && page_fault) begin
            fault_cnt <= fault_cnt + 1;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic read_csr(input csr_sel_e sel, input logic [63:0] exp, input string name);
        csr_sel <= sel;
        @(posedge clk);
        check_value(name, csr_rdata, exp);
    endtask

    task automatic write_csr(input csr_sel_e sel, input logic [63:0] val, input string name);
        csr_we    <= 1'b1;
        csr_sel   <= sel;
        csr_wdata <= val;
        @(posedge clk);
        csr_we <= 1'b0;
        read_csr(sel, val, name);
    endtask

    task automatic run_vector(input vec_t v);
        int             n;
        int             acc_start;
        int             fault_start;
        write_csr(csr_satp, v.satp, "satp");
        acc_start      = acc_cnt;
        fault_start    = fault_cnt;
        virt_a_valid   <= 1'b1;
        virt_a_opcode  <= v.op;
        virt_a_address <= v.va;
        virt_a_mask    <= 8'hff;
        virt_a_data    <= v.wdata;
        virt_a_source  <= req_src;
        n = 0;
        @(posedge clk);
        while (!virt_a_ready) begin
            n = n + 1;
            if (n > timeout_cycles) begin
                stop_with_failure("Timeout: the MMU never accepted the virtual request");
            end
            @(posedge clk);
        end
        virt_a_valid <= 1'b0;
        n = 0;
        while (!(virt_d_valid && virt_d_ready)) begin
            virt_d_ready <= reply_ready_rnd;  // Random back-pressure on the reply.
            n = n + 1;
            if (n > timeout_cycles) begin
                stop_with_failure("Timeout: no reply ever transferred on the virtual D channel");
            end
            @(posedge clk);
        end
        virt_d_ready <= 1'b0;
        check_value("virt_d_denied", 64'(virt_d_denied), 64'(v.fault));
        check_value("virt_d_source", 64'(virt_d_source), 64'(req_src));
        check_value("virt_d_opcode", 64'(virt_d_opcode),
                    (v.op == op_get) ? 64'(op_access_ack_data) : 64'(op_access_ack));
        check_value("page_fault pulses", 64'(fault_cnt - fault_start), 64'(v.fault));
        if (v.fault) begin
            check_value("final accesses", 64'(acc_cnt - acc_start), 64'd0);
            check_value("virt_d_data", virt_d_data, 64'd0);
            read_csr(csr_stval, 64'(v.va), "stval");
        end else begin
            check_value("final accesses", 64'(acc_cnt - acc_start), 64'd1);
            check_value("phy_a_address", 64'(last_pa), 64'(v.pa));
            if (v.op == op_get) begin
                check_value("virt_d_data", virt_d_data, v.rdata);
            end
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        virt_a_valid   = 1'b0;
        virt_a_opcode  = op_get;
        virt_a_address = '0;
        virt_a_mask    = '0;
        virt_a_data    = '0;
        virt_a_source  = '0;
        virt_d_ready   = 1'b0;
        csr_we         = 1'b0;
        csr_sel        = csr_satp;
        csr_wdata      = '0;

        // satp, opcode, VA, write data, expected PA, expected read data, fault.
        vecs[0] = '{64'h0, op_get, 39'h00_0012_3450, 64'h0,
                    56'h12_3450, 64'h0bad_f00d_1234_5678, 1'b0};  // Bare mode.
        vecs[1] = '{satp_sv39, op_get, 39'h00_4123_4568, 64'h0,
                    56'hc1_2345_68, 64'h1111_2222_3333_4444, 1'b0};  // 1 GiB.
        vecs[2] = '{satp_sv39, op_get, 39'h00_8061_2340, 64'h0,
                    56'h80_2123_40, 64'h5555_6666_7777_8888, 1'b0};  // 2 MiB.
        vecs[3] = '{satp_sv39, op_get, 39'h00_8080_5678, 64'h0,
                    56'h34_5678, 64'h9999_aaaa_bbbb_cccc, 1'b0};  // 4 KiB.
        vecs[4] = '{satp_sv39, op_get, 39'h00_c000_0100, 64'h0,
                    56'h0, 64'h0, 1'b1};
        vecs[5] = '{satp_sv39, op_get, 39'h01_0000_0200, 64'h0,
                    56'h0, 64'h0, 1'b1};
        vecs[6] = '{satp_sv39, op_get, 39'h00_8080_6010, 64'h0,
                    56'h0, 64'h0, 1'b1};
        vecs[7] = '{satp_sv39, op_put_full, 39'h00_8080_5ab8, 64'hdead_beef_cafe_f00d,
                    56'h34_5ab8, 64'h0, 1'b0};
        vecs[8] = '{satp_sv39, op_get, 39'h00_8080_5ab8, 64'h0,
                    56'h34_5ab8, 64'hdead_beef_cafe_f00d, 1'b0};  // Reads the put back.

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        write_csr(csr_stval, 64'h0000_0042_1357_9bdf, "stval");
        $display("test passed");
        $finish;
    end

endmodule
